//--- tb.f
+incdir+verif
design/ex_pkg.sv
design/ex_if.sv
design/ex_alu.sv
design/ex_mul.sv
design/ex_ctrl.sv
design/ex_stage_reg.sv
design/ex_top.sv
verif/tb_top.sv

//--- Makefile
# Verilator build and run of the execute stage testbench

VERILATOR ?= verilator
TOP       ?= tb_top
OBJ_DIR   ?= obj_dir
FLAGS     ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  := TESTBENCH PASSED

.PHONY: all build run clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f tb.f

# Fails unless the pass message shows up in the output
run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- verif/tb_model.svh
/*
 * Expected s3 fields, built from the RV32 op rules.
 * Included inside the testbench module. mul keeps the unsigned high half
 * in operand b, as the low half is the same for every signedness.
 */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

function automatic logic [31:0] alu_ref(ex_pkg::ex_uop_e op, logic [31:0] a, logic [31:0] b);
    case (op)
        ex_pkg::UOP_ADD:  return a + b;
        ex_pkg::UOP_SUB:  return a - b;
        ex_pkg::UOP_XOR:  return a ^ b;
        ex_pkg::UOP_OR:   return a | b;
        ex_pkg::UOP_AND:  return a & b;
        ex_pkg::UOP_SLL:  return a << b[4:0];
        ex_pkg::UOP_SRL:  return a >> b[4:0];
        ex_pkg::UOP_SRA:  return $signed(a) >>> b[4:0];
        ex_pkg::UOP_SLT:  return {31'b0, $signed(a) < $signed(b)};
        ex_pkg::UOP_SLTU: return {31'b0, a < b};
        default:          return '0;
    endcase
endfunction

function automatic logic taken_ref(ex_pkg::ex_uop_e op, logic [31:0] a, logic [31:0] b);
    case (op)
        ex_pkg::UOP_BEQ:  return a == b;
        ex_pkg::UOP_BNE:  return a != b;
        ex_pkg::UOP_BLT:  return $signed(a) < $signed(b);
        ex_pkg::UOP_BGE:  return $signed(a) >= $signed(b);
        ex_pkg::UOP_BLTU: return a < b;
        default:          return a >= b;       // BGEU
    endcase
endfunction

// Low 64 bits of the product of the extended operands
function automatic logic [63:0] mul_ref(ex_pkg::ex_uop_e op, logic [31:0] a, logic [31:0] b);
    logic [63:0] sa;
    logic [63:0] sb;
    sa = (op == ex_pkg::UOP_MULH || op == ex_pkg::UOP_MULHSU) ? {{32{a[31]}}, a} : {32'b0, a};
    sb = (op == ex_pkg::UOP_MULH) ? {{32{b[31]}}, b} : {32'b0, b};
    return sa * sb;
endfunction

function automatic ex_pkg::ex_s3_t expect_s3(ex_pkg::ex_fu_e fu, ex_pkg::ex_uop_e uop,
        logic [4:0] rd, logic [31:0] a, logic [31:0] b, logic [31:0] c);
    ex_pkg::ex_s3_t e;
    logic [63:0]    p;
    e     = '0;
    e.rd  = rd;
    e.uop = uop;
    e.fu  = fu;
    p     = mul_ref(uop, a, b);
    case (fu)
        ex_pkg::FU_ALU: e.opr_a = alu_ref(uop, a, b);
        ex_pkg::FU_MUL: begin
            e.opr_a = (uop == ex_pkg::UOP_MUL) ? p[31:0] : p[63:32];
            e.opr_b = p[63:32];                 // High half always
        end
        ex_pkg::FU_LSU: begin
            e.opr_a = a + b;                    // Address
            e.opr_b = c;                        // Store data
        end
        ex_pkg::FU_CFU: begin
            e.opr_a = (uop == ex_pkg::UOP_JALR) ? (a + b) & ~32'h1 : c & ~32'h1;
            if (uop inside {ex_pkg::UOP_BEQ, ex_pkg::UOP_BNE, ex_pkg::UOP_BLT,
                            ex_pkg::UOP_BGE, ex_pkg::UOP_BLTU, ex_pkg::UOP_BGEU})
                e.uop = taken_ref(uop, a, b) ? ex_pkg::UOP_TAKEN : ex_pkg::UOP_NOT_TAKEN;
        end
        default: begin                          // CSR pass-through
            e.opr_a = a;
            e.opr_b = c;
        end
    endcase
    return e;
endfunction

`endif

//--- verif/tb_top.sv
/*
 * Directed testbench for the execute stage. Inputs change DRIVE_DLY
 * after the rising edge, and outputs are read SETTLE_DLY after a change
 * of the inputs. Every wait for the DUT gives up after TIMEOUT cycles.
 */
module tb_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          CLK_PERIOD = 8;
    localparam int          DRIVE_DLY  = 1;
    localparam int          SETTLE_DLY = 1;
    localparam int          TIMEOUT    = 100;
    localparam logic [31:0] SEED       = 32'hf2f248a4;

    logic                      g_clk;
    logic                      g_resetn;
    logic                      i_s2_valid, i_flush, i_s3_busy;
    logic [ex_pkg::REG_AW-1:0] i_s2_rd;
    ex_pkg::ex_fu_e            i_s2_fu;
    ex_pkg::ex_uop_e           i_s2_uop;
    logic [ex_pkg::XLEN-1:0]   i_s2_opr_a, i_s2_opr_b, i_s2_opr_c;
    logic                      o_s2_busy, o_s3_valid, o_fwd_load, o_fwd_csr;
    logic [ex_pkg::REG_AW-1:0] o_s3_rd, o_fwd_rd;
    ex_pkg::ex_uop_e           o_s3_uop;
    ex_pkg::ex_fu_e            o_s3_fu;
    logic [ex_pkg::XLEN-1:0]   o_s3_opr_a, o_s3_opr_b, o_fwd_wdata;
    logic [31:0]               rng_state;
    int                        checks;
    int                        errors;

    ex_top i_dut (.*);

    initial begin
        g_clk = 1'b0;
        forever #(CLK_PERIOD / 2) g_clk = ~g_clk;
    end

`include "tb_model.svh"

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // ----------------------------------------
    // Checks and run control
    // ----------------------------------------
    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("Error: %s", what);
            errors++;
        end
    endtask

    task automatic end_run();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    endtask

    task automatic next_cycle();
        @(posedge g_clk);
        #DRIVE_DLY;
    endtask

    task automatic wait_ready(output int busy_cycles);
        busy_cycles = 0;
        while (o_s2_busy && busy_cycles < TIMEOUT) begin
            next_cycle();
            busy_cycles++;
        end
        if (o_s2_busy) begin
            $display("Error: o_s2_busy did not fall within %0d cycles", TIMEOUT);
            errors++;
            end_run();
        end
    endtask

    task automatic drive_s2(input logic [4:0] rd, input ex_pkg::ex_fu_e fu,
                            input ex_pkg::ex_uop_e uop, input logic [31:0] a,
                            input logic [31:0] b, input logic [31:0] c);
        i_s2_valid = 1'b1;
        i_s2_rd    = rd;
        i_s2_fu    = fu;
        i_s2_uop   = uop;
        i_s2_opr_a = a;
        i_s2_opr_b = b;
        i_s2_opr_c = c;
        #SETTLE_DLY;                            // Busy and forwarding follow the inputs
    endtask

    task automatic check_s3(input ex_pkg::ex_s3_t exp);
        check_true(o_s3_valid, "o_s3_valid is low where an op was expected");
        check_value("o_s3_rd", 32'(o_s3_rd), 32'(exp.rd));
        check_value("o_s3_uop", 32'(o_s3_uop), 32'(exp.uop));
        check_value("o_s3_fu", 32'(o_s3_fu), 32'(exp.fu));
        check_value("o_s3_opr_a", o_s3_opr_a, exp.opr_a);
        check_value("o_s3_opr_b", o_s3_opr_b, exp.opr_b);
    endtask

    // One op from s2 to s3, forwarding checked in its last s2 cycle
    task automatic run_op(input ex_pkg::ex_fu_e fu, input ex_pkg::ex_uop_e uop,
                          input logic [31:0] a, input logic [31:0] b, input logic [31:0] c);
        ex_pkg::ex_s3_t exp;
        logic [31:0]    r;
        int             busy_cycles;
        r   = next_rand();
        exp = expect_s3(fu, uop, r[4:0], a, b, c);
        drive_s2(exp.rd, fu, uop, a, b, c);
        wait_ready(busy_cycles);
        check_true((fu == ex_pkg::FU_MUL) == (busy_cycles > 0),
                   "o_s2_busy stall does not match the unit, only multiplies stall");
        check_value("o_fwd_rd", 32'(o_fwd_rd), 32'(exp.rd));
        check_value("o_fwd_wdata", o_fwd_wdata, exp.opr_a);
        check_value("o_fwd_load", 32'(o_fwd_load),
                    32'(fu == ex_pkg::FU_LSU && uop == ex_pkg::UOP_LOAD));
        check_value("o_fwd_csr", 32'(o_fwd_csr), 32'(fu == ex_pkg::FU_CSR));
        next_cycle();                           // Accepted at this edge
        i_s2_valid = 1'b0;
        check_s3(exp);
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic test_alu();
        ex_pkg::ex_uop_e ops [10];
        ops = '{ex_pkg::UOP_ADD, ex_pkg::UOP_SUB, ex_pkg::UOP_XOR, ex_pkg::UOP_OR,
                ex_pkg::UOP_AND, ex_pkg::UOP_SLL, ex_pkg::UOP_SRL, ex_pkg::UOP_SRA,
                ex_pkg::UOP_SLT, ex_pkg::UOP_SLTU};
        foreach (ops[i]) begin
            repeat (4) run_op(ex_pkg::FU_ALU, ops[i], next_rand(), next_rand(), next_rand());
        end
    endtask

    task automatic test_branch();
        ex_pkg::ex_uop_e ops [6];
        logic [31:0]     lhs [5];
        logic [31:0]     rhs [5];
        logic [31:0]     r;
        r   = next_rand();
        ops = '{ex_pkg::UOP_BEQ, ex_pkg::UOP_BNE, ex_pkg::UOP_BLT,
                ex_pkg::UOP_BGE, ex_pkg::UOP_BLTU, ex_pkg::UOP_BGEU};
        lhs = '{r, 32'hfffffffd, 32'h4, 32'h3, 32'h9};      // Same, sign split, plain
        rhs = '{r, 32'h4, 32'hfffffffd, 32'h9, 32'h3};
        foreach (ops[i]) begin
            for (int k = 0; k < 5; k++) begin
                run_op(ex_pkg::FU_CFU, ops[i], lhs[k], rhs[k], next_rand());
            end
        end
    endtask

    task automatic test_addr_jump_csr();
        repeat (3) begin
            run_op(ex_pkg::FU_LSU, ex_pkg::UOP_LOAD, next_rand(), next_rand(), next_rand());
            run_op(ex_pkg::FU_LSU, ex_pkg::UOP_STORE, next_rand(), next_rand(), next_rand());
            run_op(ex_pkg::FU_CSR, ex_pkg::UOP_CSR, next_rand(), next_rand(), next_rand());
        end
        run_op(ex_pkg::FU_CFU, ex_pkg::UOP_JAL, next_rand(), next_rand(), 32'h0000_1233);
        run_op(ex_pkg::FU_CFU, ex_pkg::UOP_JALR, 32'h0000_2000, 32'h11, next_rand()); // Odd sum
    endtask

    task automatic test_mul();
        ex_pkg::ex_uop_e ops [4];
        logic [31:0]     lhs [5];
        logic [31:0]     rhs [5];
        ops = '{ex_pkg::UOP_MUL, ex_pkg::UOP_MULH, ex_pkg::UOP_MULHU, ex_pkg::UOP_MULHSU};
        lhs = '{32'h80000000, 32'hffffffff, 32'h80000000, 32'h7fffffff, 32'h0};
        rhs = '{32'h80000000, 32'hffffffff, 32'hffffffff, 32'h80000000, 32'hffffffff};
        foreach (ops[i]) begin
            for (int k = 0; k < 5; k++) begin
                run_op(ex_pkg::FU_MUL, ops[i], lhs[k], rhs[k], 32'h0);
            end
            repeat (2) run_op(ex_pkg::FU_MUL, ops[i], next_rand(), next_rand(), 32'h0);
        end
    endtask

    task automatic test_backpressure();
        ex_pkg::ex_uop_e uops [3];
        ex_pkg::ex_s3_t  exp [3];
        logic [31:0]     a [3];
        logic [31:0]     b [3];
        int              busy_cycles;
        int              seen;
        int              sent;
        logic            accept;
        uops = '{ex_pkg::UOP_ADD, ex_pkg::UOP_XOR, ex_pkg::UOP_SUB};
        for (int i = 0; i < 3; i++) begin
            a[i]   = next_rand();
            b[i]   = next_rand();
            exp[i] = expect_s3(ex_pkg::FU_ALU, uops[i], 5'(i + 1), a[i], b[i], 32'h0);
        end
        drive_s2(exp[0].rd, ex_pkg::FU_ALU, uops[0], a[0], b[0], 32'h0);
        wait_ready(busy_cycles);
        next_cycle();                           // First op enters s3
        i_s3_busy = 1'b1;                       // Writeback stalls on it
        drive_s2(exp[1].rd, ex_pkg::FU_ALU, uops[1], a[1], b[1], 32'h0);  // Waits behind s3
        repeat (4) begin
            check_true(o_s2_busy, "o_s2_busy is low while s3 is held");
            check_s3(exp[0]);
            next_cycle();
        end
        i_s3_busy = 1'b0;
        seen      = 0;
        sent      = 1;
        for (int n = 0; n < TIMEOUT && seen < 3; n++) begin
            #SETTLE_DLY;
            if (o_s3_valid) begin
                check_s3(exp[seen]);            // Consumed at the coming edge
                seen++;
            end
            accept = i_s2_valid && !o_s2_busy;
            next_cycle();
            if (accept) begin
                sent++;
                if (sent < 3) drive_s2(exp[sent].rd, ex_pkg::FU_ALU, uops[sent],
                                       a[sent], b[sent], 32'h0);
                else i_s2_valid = 1'b0;
            end
        end
        check_true(seen == 3, "an op was lost after back-pressure");
        check_true(!o_s3_valid, "an extra op appeared in s3 after the sequence");
    endtask

    task automatic test_flush();
        logic [31:0] r;
        r = next_rand();
        drive_s2(r[4:0], ex_pkg::FU_MUL, ex_pkg::UOP_MULH, next_rand(), next_rand(), 32'h0);
        repeat (5) begin
            check_true(o_s2_busy, "o_s2_busy is low while a multiply runs");
            next_cycle();
        end
        i_flush    = 1'b1;
        i_s2_valid = 1'b0;                      // s2 op killed by the flush
        next_cycle();
        i_flush = 1'b0;
        // A multiply left running would hand its own product to this one
        run_op(ex_pkg::FU_MUL, ex_pkg::UOP_MULHSU, next_rand(), next_rand(), 32'h0);
        run_op(ex_pkg::FU_ALU, ex_pkg::UOP_ADD, next_rand(), next_rand(), 32'h0);
        i_s3_busy = 1'b1;                       // Add held in s3
        i_flush   = 1'b1;
        next_cycle();
        i_flush   = 1'b0;
        i_s3_busy = 1'b0;
        check_true(!o_s3_valid, "o_s3_valid stayed high through a flush");
        run_op(ex_pkg::FU_ALU, ex_pkg::UOP_SUB, next_rand(), next_rand(), 32'h0);
    endtask

    initial begin
        rng_state  = SEED;
        checks     = 0;
        errors     = 0;
        g_resetn   = 1'b0;
        i_s2_valid = 1'b0;
        i_s2_rd    = '0;
        i_s2_fu    = ex_pkg::FU_ALU;
        i_s2_uop   = ex_pkg::UOP_ADD;
        i_s2_opr_a = '0;
        i_s2_opr_b = '0;
        i_s2_opr_c = '0;
        i_flush    = 1'b0;
        i_s3_busy  = 1'b0;
        repeat (16) @(posedge g_clk);
        #DRIVE_DLY;
        g_resetn = 1'b1;
        check_true(!o_s3_valid && !o_s2_busy, "stage is not idle after reset");
        test_alu();
        test_branch();
        test_addr_jump_csr();
        test_mul();
        test_backpressure();
        test_flush();
        end_run();
    end

endmodule

//--- design/ex_top.sv
/*
 * Execute stage between decode (s2) and writeback (s3).
 * No traps are raised here. Multiplies stall s2 for MUL_STEPS+1
 * cycles, all other ops pass in one.
 */
module ex_top (
    input  logic                      g_clk,
    input  logic                      g_resetn,
    input  logic                      i_s2_valid,
    input  logic [ex_pkg::REG_AW-1:0] i_s2_rd,
    input  ex_pkg::ex_fu_e            i_s2_fu,
    input  ex_pkg::ex_uop_e           i_s2_uop,
    input  logic [ex_pkg::XLEN-1:0]   i_s2_opr_a,
    input  logic [ex_pkg::XLEN-1:0]   i_s2_opr_b,
    input  logic [ex_pkg::XLEN-1:0]   i_s2_opr_c,
    input  logic                      i_flush,
    input  logic                      i_s3_busy,
    output logic                      o_s2_busy,
    output logic                      o_s3_valid,
    output logic [ex_pkg::REG_AW-1:0] o_s3_rd,
    output ex_pkg::ex_uop_e           o_s3_uop,
    output ex_pkg::ex_fu_e            o_s3_fu,
    output logic [ex_pkg::XLEN-1:0]   o_s3_opr_a,
    output logic [ex_pkg::XLEN-1:0]   o_s3_opr_b,
    output logic [ex_pkg::REG_AW-1:0] o_fwd_rd,
    output logic [ex_pkg::XLEN-1:0]   o_fwd_wdata,
    output logic                      o_fwd_load,
    output logic                      o_fwd_csr
);

    ex_pkg::ex_s3_t next;                       // Payload into s3 register
    ex_pkg::ex_s3_t s3;                         // Registered payload
    logic           load;
    logic           reg_flush;
    logic           reg_busy;

    ex_alu_if alu_if ();
    ex_mul_if mul_if ();

    // ----------------------------------------
    // Units
    // ----------------------------------------
    ex_ctrl i_ctrl (
        .i_s2_valid (i_s2_valid), .i_s2_rd   (i_s2_rd),    .i_s2_fu    (i_s2_fu),
        .i_s2_uop   (i_s2_uop),   .i_s2_opr_a(i_s2_opr_a), .i_s2_opr_c (i_s2_opr_c),
        .i_flush    (i_flush),    .alu       (alu_if),     .mul        (mul_if),
        .i_reg_busy (reg_busy),   .o_s2_busy (o_s2_busy),  .o_next     (next),
        .o_load     (load),       .o_reg_flush(reg_flush), .o_fwd_rd   (o_fwd_rd),
        .o_fwd_wdata(o_fwd_wdata), .o_fwd_load(o_fwd_load), .o_fwd_csr (o_fwd_csr)
    );

    ex_alu i_alu (.alu(alu_if), .i_lhs(i_s2_opr_a), .i_rhs(i_s2_opr_b));

    ex_mul i_mul (
        .g_clk(g_clk), .g_resetn(g_resetn), .mul(mul_if),
        .i_rs1(i_s2_opr_a), .i_rs2(i_s2_opr_b)
    );

    ex_stage_reg i_stage_reg (
        .g_clk    (g_clk),     .g_resetn (g_resetn), .i_next    (next),
        .i_load   (load),      .i_flush  (reg_flush), .i_s3_busy(i_s3_busy),
        .o_busy   (reg_busy),  .o_s3_valid(o_s3_valid), .o_s3    (s3)
    );

    // Unpack for writeback
    assign o_s3_rd    = s3.rd;
    assign o_s3_uop   = s3.uop;
    assign o_s3_fu    = s3.fu;
    assign o_s3_opr_a = s3.opr_a;
    assign o_s3_opr_b = s3.opr_b;

endmodule

//--- design/ex_stage_reg.sv
/*
 * s2-to-s3 pipeline register. Valid/busy strobes only, no skid buffer.
 * The payload holds while valid and i_s3_busy are both high.
 */
module ex_stage_reg (
    input  logic           g_clk,
    input  logic           g_resetn,
    input  ex_pkg::ex_s3_t i_next,              // Payload from control
    input  logic           i_load,              // Capture i_next
    input  logic           i_flush,             // Drop current s3 op
    input  logic           i_s3_busy,           // Writeback stalled
    output logic           o_busy,              // Register cannot take more
    output logic           o_s3_valid,
    output ex_pkg::ex_s3_t o_s3
);

    // ----------------------------------------
    // Valid tracking
    // ----------------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            o_s3_valid <= 1'b0;
        end else if (i_flush) begin
            o_s3_valid <= 1'b0;                 // Flush wins over load
        end else if (i_load) begin
            o_s3_valid <= 1'b1;
        end else if (!i_s3_busy) begin
            o_s3_valid <= 1'b0;                 // Consumed by writeback
        end
    end

    // Payload
    always_ff @(posedge g_clk) begin
        if (i_load) begin
            o_s3 <= i_next;
        end
    end

    assign o_busy = o_s3_valid && i_s3_busy;

endmodule

//--- design/ex_ctrl.sv
/*
 * Execute control: stall, branch resolution, s3 payload and forwarding.
 * Only the multiplier can stall on its own. Forward outputs follow the
 * s2 inputs combinationally, whether or not s2 is valid.
 */
module ex_ctrl (
    input  logic                      i_s2_valid,
    input  logic [ex_pkg::REG_AW-1:0] i_s2_rd,
    input  ex_pkg::ex_fu_e            i_s2_fu,
    input  ex_pkg::ex_uop_e           i_s2_uop,
    input  logic [ex_pkg::XLEN-1:0]   i_s2_opr_a,
    input  logic [ex_pkg::XLEN-1:0]   i_s2_opr_c,
    input  logic                      i_flush,
    ex_alu_if.ctrl                    alu,
    ex_mul_if.ctrl                    mul,
    input  logic                      i_reg_busy,   // s3 register holding
    output logic                      o_s2_busy,
    output ex_pkg::ex_s3_t            o_next,
    output logic                      o_load,       // s2 op moves to s3
    output logic                      o_reg_flush,
    output logic [ex_pkg::REG_AW-1:0] o_fwd_rd,
    output logic [ex_pkg::XLEN-1:0]   o_fwd_wdata,
    output logic                      o_fwd_load,
    output logic                      o_fwd_csr
);

    logic fu_mul;
    logic is_cond;                              // Conditional branch
    logic taken;
    logic mul_hi;                               // Result from upper product half

    assign fu_mul  = i_s2_fu == ex_pkg::FU_MUL;
    assign is_cond = i_s2_uop inside {ex_pkg::UOP_BEQ, ex_pkg::UOP_BNE, ex_pkg::UOP_BLT,
                                      ex_pkg::UOP_BGE, ex_pkg::UOP_BLTU, ex_pkg::UOP_BGEU};
    assign mul_hi  = i_s2_uop inside {ex_pkg::UOP_MULH, ex_pkg::UOP_MULHU,
                                      ex_pkg::UOP_MULHSU};

    // ----------------------------------------
    // Unit control and stall
    // ----------------------------------------
    assign alu.op           = i_s2_uop;
    assign alu.cmp_unsigned = i_s2_uop inside {ex_pkg::UOP_SLTU, ex_pkg::UOP_BLTU,
                                               ex_pkg::UOP_BGEU};
    assign mul.op    = i_s2_uop;
    assign mul.start = i_s2_valid && fu_mul;
    assign mul.clear = o_load || i_flush;       // Release product or abort

    assign o_s2_busy   = i_reg_busy || (i_s2_valid && fu_mul && !mul.ready);
    assign o_load      = i_s2_valid && !o_s2_busy;
    assign o_reg_flush = i_flush;

    always_comb begin
        case (i_s2_uop)
            ex_pkg::UOP_BEQ:  taken = alu.eq;
            ex_pkg::UOP_BNE:  taken = !alu.eq;
            ex_pkg::UOP_BLT,
            ex_pkg::UOP_BLTU: taken = alu.lt;   // Signedness via cmp_unsigned
            ex_pkg::UOP_BGE,
            ex_pkg::UOP_BGEU: taken = !alu.lt;
            default:          taken = 1'b0;
        endcase
    end

    // ----------------------------------------
    // s3 payload
    // ----------------------------------------
    always_comb begin
        o_next       = '0;
        o_next.rd    = i_s2_rd;
        o_next.uop   = i_s2_uop;
        o_next.fu    = i_s2_fu;
        case (i_s2_fu)
            ex_pkg::FU_ALU: o_next.opr_a = alu.result;
            ex_pkg::FU_MUL: begin
                o_next.opr_a = mul_hi ? mul.product[2*ex_pkg::XLEN-1:ex_pkg::XLEN] :
                                        mul.product[ex_pkg::XLEN-1:0];
                o_next.opr_b = mul.product[2*ex_pkg::XLEN-1:ex_pkg::XLEN];
            end
            ex_pkg::FU_LSU: begin
                o_next.opr_a = alu.sum;         // Effective address
                o_next.opr_b = i_s2_opr_c;      // Store data
            end
            ex_pkg::FU_CFU: begin
                o_next.opr_a = (i_s2_uop == ex_pkg::UOP_JALR) ?
                               {alu.sum[ex_pkg::XLEN-1:1], 1'b0} :
                               {i_s2_opr_c[ex_pkg::XLEN-1:1], 1'b0};
                if (is_cond) o_next.uop = taken ? ex_pkg::UOP_TAKEN : ex_pkg::UOP_NOT_TAKEN;
            end
            ex_pkg::FU_CSR: begin
                o_next.opr_a = i_s2_opr_a;
                o_next.opr_b = i_s2_opr_c;
            end
            default: ;
        endcase
    end

    // Forwarding to decode
    assign o_fwd_rd    = i_s2_rd;
    assign o_fwd_wdata = o_next.opr_a;
    assign o_fwd_load  = i_s2_fu == ex_pkg::FU_LSU && i_s2_uop == ex_pkg::UOP_LOAD;
    assign o_fwd_csr   = i_s2_fu == ex_pkg::FU_CSR;

endmodule

//--- design/ex_mul.sv
/*
 * Radix-2 shift-add multiplier, MUL_STEPS cycles per product.
 * Works on magnitudes and negates at the output. mulhsu treats only
 * rs1 as signed. Operands must stay stable only in the start cycle.
 */
module ex_mul (
    input  logic                    g_clk,
    input  logic                    g_resetn,
    ex_mul_if.mul                   mul,
    input  logic [ex_pkg::XLEN-1:0] i_rs1,      // Multiplicand source
    input  logic [ex_pkg::XLEN-1:0] i_rs2       // Multiplier source
);

    typedef enum logic [1:0] {MUL_IDLE, MUL_RUN, MUL_DONE} mul_state_e;

    mul_state_e                           state;
    logic [$clog2(ex_pkg::MUL_STEPS)-1:0] count;        // Steps done so far
    logic [2*ex_pkg::XLEN-1:0]            prod;         // {partial hi, multiplier lo}
    logic [ex_pkg::XLEN-1:0]              mcand;        // Multiplicand magnitude
    logic                                 neg;          // Negate final product
    logic                                 a_neg;
    logic                                 b_neg;
    logic [ex_pkg::XLEN-1:0]              a_mag;
    logic [ex_pkg::XLEN-1:0]              b_mag;
    logic [ex_pkg::XLEN:0]                step_sum;     // Carry kept for the shift

    // Low product is sign independent, so mul runs unsigned
    assign a_neg = (mul.op == ex_pkg::UOP_MULH || mul.op == ex_pkg::UOP_MULHSU) &&
                   i_rs1[ex_pkg::XLEN-1];
    assign b_neg = mul.op == ex_pkg::UOP_MULH && i_rs2[ex_pkg::XLEN-1];
    assign a_mag = a_neg ? -i_rs1 : i_rs1;
    assign b_mag = b_neg ? -i_rs2 : i_rs2;

    assign step_sum = {1'b0, prod[2*ex_pkg::XLEN-1:ex_pkg::XLEN]} +
                      (prod[0] ? {1'b0, mcand} : '0);

    // ----------------------------------------
    // Control
    // ----------------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            state <= MUL_IDLE;
            count <= '0;
        end else if (mul.clear) begin
            state <= MUL_IDLE;                  // Consumed, flushed or aborted
        end else begin
            case (state)
                MUL_IDLE: if (mul.start) begin
                    state <= MUL_RUN;
                    count <= '0;
                end
                MUL_RUN: begin
                    count <= count + 1'b1;
                    if (int'(count) == ex_pkg::MUL_STEPS - 1) state <= MUL_DONE;
                end
                default: ;                      // Hold product until clear
            endcase
        end
    end

    // Datapath
    always_ff @(posedge g_clk) begin
        if (state == MUL_IDLE && mul.start) begin
            prod  <= {{ex_pkg::XLEN{1'b0}}, b_mag};
            mcand <= a_mag;
            neg   <= a_neg ^ b_neg;
        end else if (state == MUL_RUN) begin
            prod  <= {step_sum, prod[ex_pkg::XLEN-1:1]};   // Add then shift right
        end
    end

    assign mul.ready   = state == MUL_DONE;
    assign mul.product = neg ? -prod : prod;

endmodule

//--- design/ex_alu.sv
/*
 * Single-cycle integer ALU. Shift amount is the low 5 bits of rhs.
 * Sum, lt and eq are produced for every op so branches and address
 * generation can use them. Non-ALU ops give a zero result.
 */
module ex_alu (
    ex_alu_if.alu                   alu,
    input  logic [ex_pkg::XLEN-1:0] i_lhs,      // Operand a
    input  logic [ex_pkg::XLEN-1:0] i_rhs       // Operand b
);

    logic [ex_pkg::XLEN:0]   diff;              // Extra bit gives unsigned borrow
    logic [4:0]              shamt;
    logic                    signed_lt;

    assign diff      = {1'b0, i_lhs} - {1'b0, i_rhs};
    assign shamt     = i_rhs[4:0];
    // Signs differ: lhs sign decides, else the difference sign
    assign signed_lt = (i_lhs[ex_pkg::XLEN-1] != i_rhs[ex_pkg::XLEN-1]) ?
                       i_lhs[ex_pkg::XLEN-1] : diff[ex_pkg::XLEN-1];

    assign alu.sum = i_lhs + i_rhs;             // Shared with LSU and JALR
    assign alu.eq  = i_lhs == i_rhs;
    assign alu.lt  = alu.cmp_unsigned ? diff[ex_pkg::XLEN] : signed_lt;

    // ----------------------------------------
    // Result select
    // ----------------------------------------
    always_comb begin
        case (alu.op)
            ex_pkg::UOP_ADD:  alu.result = alu.sum;
            ex_pkg::UOP_SUB:  alu.result = diff[ex_pkg::XLEN-1:0];
            ex_pkg::UOP_XOR:  alu.result = i_lhs ^ i_rhs;
            ex_pkg::UOP_OR:   alu.result = i_lhs | i_rhs;
            ex_pkg::UOP_AND:  alu.result = i_lhs & i_rhs;
            ex_pkg::UOP_SLL:  alu.result = i_lhs << shamt;
            ex_pkg::UOP_SRL:  alu.result = i_lhs >> shamt;
            ex_pkg::UOP_SRA:  alu.result = $signed(i_lhs) >>> shamt;   // Sign fill
            ex_pkg::UOP_SLT,
            ex_pkg::UOP_SLTU: alu.result = {{(ex_pkg::XLEN-1){1'b0}}, alu.lt};
            default:          alu.result = '0;  // Not an ALU op
        endcase
    end

endmodule

//--- design/ex_if.sv
/*
 * Control-to-unit bundles inside the execute stage.
 * ALU operands travel as plain ports, not through this interface.
 */
interface ex_alu_if;
    ex_pkg::ex_uop_e           op;              // Requested operation
    logic                      cmp_unsigned;    // Unsigned compare for lt
    logic                      lt;              // lhs < rhs
    logic                      eq;              // lhs == rhs
    logic [ex_pkg::XLEN-1:0]   sum;             // lhs + rhs, always valid
    logic [ex_pkg::XLEN-1:0]   result;          // Op result

    modport ctrl (output op, cmp_unsigned, input lt, eq, sum, result);
    modport alu  (input op, cmp_unsigned, output lt, eq, sum, result);
endinterface

interface ex_mul_if;
    logic                      start;           // Begin when idle
    ex_pkg::ex_uop_e           op;              // Mul variant, sets signedness
    logic                      clear;           // Drop result or abort
    logic                      ready;           // Product valid, held till clear
    logic [2*ex_pkg::XLEN-1:0] product;         // Full 64-bit product

    modport ctrl (output start, op, clear, input ready, product);
    modport mul  (input start, op, clear, output ready, product);
endinterface

//--- design/ex_pkg.sv
/*
 * Shared widths, enums and the s3 payload of the execute stage.
 * RV32 only. Uop encodings are local to this stage and are not the
 * decode encodings of any other pipeline.
 */
package ex_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int XLEN      = 32;              // Data path width
    localparam int REG_AW    = 5;               // Register address width
    localparam int MUL_STEPS = 32;              // Shift-add iterations per multiply

    // Functional unit select
    typedef enum logic [2:0] {
        FU_ALU,                                 // Integer ALU
        FU_MUL,                                 // Iterative multiplier
        FU_LSU,                                 // Load/store address gen
        FU_CFU,                                 // Branches and jumps
        FU_CSR                                  // CSR operand pass
    } ex_fu_e;

    // Micro-ops for all units
    typedef enum logic [4:0] {
        UOP_ADD, UOP_SUB, UOP_XOR, UOP_OR, UOP_AND,
        UOP_SLL, UOP_SRL, UOP_SRA, UOP_SLT, UOP_SLTU,
        UOP_MUL, UOP_MULH, UOP_MULHU, UOP_MULHSU,
        UOP_LOAD, UOP_STORE,
        UOP_BEQ, UOP_BNE, UOP_BLT, UOP_BGE, UOP_BLTU, UOP_BGEU,
        UOP_JAL, UOP_JALR,
        UOP_CSR,
        UOP_TAKEN,                              // Resolved branch, taken
        UOP_NOT_TAKEN                           // Resolved branch, fall through
    } ex_uop_e;

    // ----------------------------------------
    // Payload handed to writeback
    // ----------------------------------------
    typedef struct packed {
        logic [REG_AW-1:0] rd;                  // Destination register
        ex_uop_e           uop;                 // Possibly rewritten uop
        ex_fu_e            fu;                  // Unit that produced it
        logic [XLEN-1:0]   opr_a;               // Result / address / target
        logic [XLEN-1:0]   opr_b;               // Store data, high product, CSR
    } ex_s3_t;

endpackage
